//--- dv/elip_stim.txt
# L chan idx data | R addr exp_data exp_ecc exp_err | S stall_cycles | W wait_cycles
# all values hex, ecc per the SEC-DED rule, channel 0 at 0100 and channel 1 at 0140
W 4
L 0 00 1234
L 0 01 0001
L 0 10 BEEF
L 0 1F 8000
L 1 00 A5A5
L 1 05 0F00
L 1 11 7001
L 1 1F FFFF
L 2 03 C350
# back to back reads across channels and unmapped space
R 0100 1234 07 0
R 0120 0000 00 1
R 0140 A5A5 30 0
R 00FF 0000 00 1
R 0101 0001 01 0
R 0145 0F00 24 0
R 013F 0000 00 1
R 0110 BEEF 13 0
R 0151 7001 2D 0
R 0160 0000 00 1
R 011F 8000 10 0
R 015F FFFF 30 0
R 0103 0000 00 0
R 0143 0000 00 0
W 10
L 0 07 00FF
L 1 1E C350
# consumer withholds credits while the master keeps reading
S 12
R 0107 00FF 28 0
R 015E C350 1E 0
R FFFF 0000 00 1
R 0107 00FF 28 0
R 0000 0000 00 1
R 015E C350 1E 0
W 4

//--- dv/elip_tb.sv
// Testbench for elip_subsystem: clock, reset, stimulus reader, credit models, checks, timeout.

module elip_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    REQ_CREDITS = 4;
    localparam int    RSP_CREDITS = 2;
    localparam string STIM_FILE   = "dv/elip_stim.txt";

    logic                 elip;
    logic                 rst;
    elip_pkg::elip_req_t  req;
    logic                 req_valid;
    logic                 req_credit;
    elip_pkg::elip_rsp_t  rsp;
    logic                 rsp_valid;
    logic                 rsp_credit;
    elip_pkg::tdma_load_t load;
    logic                 load_valid;

    elip_pkg::elip_rsp_t exp_q [$];    // expected responses in request order.
    int err_val     = 0;
    int err_other   = 0;
    int limit       = 0;               // timeout in cycles.
    int credits     = REQ_CREDITS;     // master's request credits.
    int credit_seen = 0;
    int owed        = 0;               // consumer credits not yet returned.
    int stall_left  = 0;
    int stall_rsp   = 0;
    int n_req       = 0;
    int n_credit    = 0;

    elip_subsystem dut0 (
        .elip       (elip),
        .rst        (rst),
        .req        (req),
        .req_valid  (req_valid),
        .req_credit (req_credit),
        .rsp        (rsp),
        .rsp_valid  (rsp_valid),
        .rsp_credit (rsp_credit),
        .load       (load),
        .load_valid (load_valid)
    );

    initial begin
        elip = 1'b0;
        forever #10 elip = ~elip;
    end

    task automatic report_counts();
        $display("errors: %0d value mismatches, %0d other failures", err_val, err_other);
    endtask

    task automatic check_value(input string name, input logic [15:0] want,
                               input logic [15:0] got);
        assert (got === want) else begin
            $display("ERR %0t %s expected %h got %h", $time, name, want, got);
            err_val++;
        end
    endtask

    function automatic bit skip_line(input string line);
        return line.len() == 0 || line.getc(0) inside {"#", " ", "\n", "\r"};
    endfunction

    // ------------------------------
    // one cycle of monitor and consumer
    // ------------------------------
    task automatic tick();
        elip_pkg::elip_rsp_t head;
        @(negedge elip);
        credits     = credits + credit_seen;  // usable one edge after the pulse.
        credit_seen = 0;
        if (n_req == 0) begin
            assert (!rsp_valid && !req_credit) else begin
                $display("response or credit at %0t before any request", $time);
                err_other++;
            end
        end
        if (req_credit) begin
            credit_seen = 1;
            n_credit++;
        end
        if (rsp_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("response at %0t with no request outstanding", $time);
                err_other++;
            end
            if (exp_q.size() != 0) begin
                head = exp_q.pop_front();
                check_value("rsp.data", head.word.data, rsp.word.data);
                check_value("rsp.ecc", 16'(head.word.ecc), 16'(rsp.word.ecc));
                check_value("rsp.err", 16'(head.err), 16'(rsp.err));
            end
            owed++;
            assert (owed <= RSP_CREDITS) else begin
                $display("response at %0t sent without a free response credit", $time);
                err_other++;
            end
            if (stall_left > 0) begin
                stall_rsp++;
                assert (stall_rsp <= RSP_CREDITS) else begin
                    $display("more responses than credits during a stall at %0t", $time);
                    err_other++;
                end
            end
        end
        req_valid  = 1'b0;
        load_valid = 1'b0;
        rsp_credit = 1'b0;
        if (stall_left > 0) begin
            stall_left--;
        end else if (owed > 0) begin
            rsp_credit = 1'b1;                // one credit back per cycle.
            owed--;
        end
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin
        int                  fd;
        int                  n;
        int                  n_lines;
        string               line;
        byte                 kind;
        logic [31:0]         f0, f1, f2, f3;
        elip_pkg::elip_rsp_t want;
        rst        = 1'b1;
        req        = '0;
        req_valid  = 1'b0;
        rsp_credit = 1'b0;
        load       = '0;
        load_valid = 1'b0;
        n_lines    = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file %s", STIM_FILE);
            err_other++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (!skip_line(line)) n_lines++;
            end
            $fclose(fd);
        end
        limit = 64 * n_lines + 200;
        repeat (16) @(posedge elip);
        @(negedge elip);
        rst = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if (skip_line(line)) continue;
                kind = line.getc(0);
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", f0, f1, f2, f3);
                case (kind)
                    "L": begin
                        load.chan  = f0[3:0];
                        load.idx   = f1[4:0];
                        load.data  = f2[15:0];
                        load_valid = 1'b1;
                        tick();
                    end
                    "R": begin
                        while (credits == 0) tick();  // master waits for a credit.
                        assert (exp_q.size() < REQ_CREDITS) else begin
                            $display("master exceeds its request credits at %0t", $time);
                            err_other++;
                        end
                        want.word.data = f1[15:0];
                        want.word.ecc  = f2[5:0];
                        want.err       = f3[0];
                        exp_q.push_back(want);
                        req.addr  = f0[15:0];
                        req_valid = 1'b1;
                        credits--;
                        n_req++;
                        tick();
                    end
                    "S": begin
                        stall_left = int'(f0);
                        stall_rsp  = 0;
                    end
                    "W": repeat (f0) tick();
                    default: begin
                        $display("unknown stimulus line (%0d fields): %s", n, line);
                        err_other++;
                    end
                endcase
            end
            $fclose(fd);
        end
        while (exp_q.size() != 0 || owed != 0) tick();
        repeat (2) tick();
        assert (n_credit == n_req && credits == REQ_CREDITS) else begin
            $display("%0d req_credit pulses for %0d requests, master holds %0d credits",
                     n_credit, n_req, credits);
            err_other++;
        end
        report_counts();
        if (err_val == 0 && err_other == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // ------------------------------
    // timeout
    // ------------------------------
    initial begin
        int cycles;
        cycles = 0;
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge elip);
            cycles++;
        end
        $display("run did not finish within %0d cycles", limit);
        report_counts();
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- rtl/elip_demuxer.sv
// Address decode, table read routing, response mux/buffer and request/response credit loops.

module elip_demuxer #(
    parameter int                   DSI_CHANNELS = elip_pkg::DSI_CHANNELS_DEF,
    parameter elip_pkg::elip_addr_t TDMA_BASE    = elip_pkg::TDMA_BASE_DEF,
    parameter elip_pkg::elip_addr_t TDMA_STRIDE  = elip_pkg::TDMA_STRIDE_DEF,
    parameter int                   REQ_CREDITS  = 4,
    parameter int                   RSP_CREDITS  = 2
) (
    input  logic                  elip,
    input  logic                  rst,
    input  elip_pkg::elip_req_t   req,
    input  logic                  req_valid,
    output logic                  req_credit,
    output logic [DSI_CHANNELS-1:0] tdma_rd,
    output elip_pkg::tdma_idx_t   tdma_idx,
    input  elip_pkg::data_ecc_t   tdma_data [DSI_CHANNELS],
    output elip_pkg::elip_rsp_t   rsp,
    output logic                  rsp_valid,
    input  logic                  rsp_credit
);

    localparam int PTR_W = (REQ_CREDITS > 1) ? $clog2(REQ_CREDITS) : 1;
    localparam int CNT_W = $clog2(REQ_CREDITS + 1);
    localparam int CRD_W = $clog2(RSP_CREDITS + 1);

    // ------------------------------
    // address decode
    // ------------------------------
    logic [DSI_CHANNELS-1:0] hit;
    elip_pkg::tdma_idx_t     idx;
    logic [16:0]             base;  // one spare bit so base + size cannot wrap.

    always_comb begin
        hit  = '0;
        idx  = '0;
        base = '0;
        for (int c = 0; c < DSI_CHANNELS; c++) begin
            base = 17'(TDMA_BASE) + 17'(c * TDMA_STRIDE);
            if (req_valid && ({1'b0, req.addr} >= base) &&
                ({1'b0, req.addr} < base + 17'(elip_pkg::TDMA_WORDS))) begin
                hit[c] = 1'b1;
                idx    = elip_pkg::tdma_idx_t'(req.addr - base[15:0]);
            end
        end
    end

    // ------------------------------
    // two stage read pipeline
    // ------------------------------
    logic [DSI_CHANNELS-1:0] hit_q;  // stage 1 drives the table reads.
    logic [DSI_CHANNELS-1:0] sel_q;  // stage 2 selects the table data.
    elip_pkg::tdma_idx_t     idx_q;
    logic                    v1_q;
    logic                    v2_q;

    always_ff @(posedge elip) begin
        if (rst) begin
            hit_q <= '0;
            sel_q <= '0;
            v1_q  <= 1'b0;
            v2_q  <= 1'b0;
        end else begin
            hit_q <= hit;
            sel_q <= hit_q;
            v1_q  <= req_valid;
            v2_q  <= v1_q;
        end
    end

    always_ff @(posedge elip) begin
        idx_q <= idx;
    end

    assign tdma_rd  = hit_q;
    assign tdma_idx = idx_q;

    // ------------------------------
    // response mux
    // ------------------------------
    elip_pkg::elip_ecc_t fill_ecc;
    elip_pkg::data_ecc_t tbl_word;
    elip_pkg::elip_rsp_t rsp_d;

    elip_ecc_enc u_fill_ecc (
        .data ('0),
        .ecc  (fill_ecc)
    );

    always_comb begin
        tbl_word = '0;
        for (int c = 0; c < DSI_CHANNELS; c++) begin
            if (sel_q[c]) begin
                tbl_word = tbl_word | tdma_data[c];  // one-hot and-or mux.
            end
        end
        if (sel_q == '0) begin
            rsp_d = '{word: '{data: '0, ecc: fill_ecc}, err: 1'b1};  // unmapped.
        end else begin
            rsp_d = '{word: tbl_word, err: 1'b0};
        end
    end

    // ------------------------------
    // response buffer and credits
    // ------------------------------
    elip_pkg::elip_rsp_t rsp_buf [REQ_CREDITS];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    buf_cnt;
    logic [CRD_W-1:0]    rsp_cnt;
    logic                pop;

    assign pop        = (buf_cnt != '0) && (rsp_cnt != '0);
    assign rsp_valid  = pop;
    assign req_credit = pop;               // credit goes back with each departure.
    assign rsp        = rsp_buf[rd_ptr];

    always_ff @(posedge elip) begin
        if (v2_q) begin
            rsp_buf[wr_ptr] <= rsp_d;
        end
    end

    always_ff @(posedge elip) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            buf_cnt <= '0;
            rsp_cnt <= CRD_W'(RSP_CREDITS);
        end else begin
            if (v2_q) begin
                wr_ptr <= (wr_ptr == PTR_W'(REQ_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(REQ_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            buf_cnt <= buf_cnt + CNT_W'(v2_q) - CNT_W'(pop);
            rsp_cnt <= rsp_cnt + CRD_W'(rsp_credit) - CRD_W'(pop);
        end
    end

    // ------------------------------
    // protocol checks
    // ------------------------------
    a_req_credit: assert property (@(posedge elip) disable iff (rst)
        req_valid |-> (int'(buf_cnt) + int'(v1_q) + int'(v2_q)) < REQ_CREDITS)
        else $error("request without a free credit");

    a_rsp_cnt_max: assert property (@(posedge elip) disable iff (rst)
        rsp_cnt <= CRD_W'(RSP_CREDITS))
        else $error("consumer returned too many credits");

endmodule

//--- rtl/elip_ecc_enc.sv
// Combinational 16-to-6 SEC-DED check-bit generator.

module elip_ecc_enc (
    input  elip_pkg::elip_data_t data,
    output elip_pkg::elip_ecc_t  ecc
);

    // ------------------------------
    // hamming part
    // ------------------------------
    // data bit i sits at code position i+1, check bit k covers
    // every position with bit k set.
    logic [4:0] hamming;

    always_comb begin
        hamming = '0;
        for (int k = 0; k < 5; k++) begin
            for (int i = 0; i < 16; i++) begin
                if (((i + 1) & (1 << k)) != 0) begin
                    hamming[k] = hamming[k] ^ data[i];
                end
            end
        end
    end

    // ------------------------------
    // overall parity
    // ------------------------------
    logic parity;

    assign parity = (^data) ^ (^hamming);  // double error detection.

    assign ecc = {parity, hamming};

endmodule

//--- rtl/elip_pkg.sv
// ELIP bus widths, request/response/load structs and default TDMA address map.

package elip_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    typedef logic [15:0] elip_addr_t;   // bus address.
    typedef logic [15:0] elip_data_t;   // data word.
    typedef logic [5:0]  elip_ecc_t;    // sec-ded check bits.
    typedef logic [4:0]  tdma_idx_t;    // word index within one table.
    typedef logic [3:0]  tdma_chan_t;   // dsi channel number.

    localparam int TDMA_WORDS = 2 ** $bits(tdma_idx_t); // words per channel.

    // ------------------------------
    // structs
    // ------------------------------
    typedef struct packed {
        elip_data_t data;
        elip_ecc_t  ecc;
    } data_ecc_t;

    typedef struct packed {
        elip_addr_t addr;
    } elip_req_t;

    typedef struct packed {
        data_ecc_t word;
        logic      err;                 // set for unmapped reads.
    } elip_rsp_t;

    typedef struct packed {
        tdma_chan_t chan;
        tdma_idx_t  idx;
        elip_data_t data;
    } tdma_load_t;

    // ------------------------------
    // default address map
    // ------------------------------
    localparam int         DSI_CHANNELS_DEF = 2;
    localparam elip_addr_t TDMA_BASE_DEF    = 16'h0100;  // channel 0 base.
    localparam elip_addr_t TDMA_STRIDE_DEF  = 16'h0040;  // base to base distance.

endpackage

//--- rtl/elip_subsystem.sv
// Top level with the ELIP demuxer, per-channel TDMA tables and load routing.

module elip_subsystem #(
    parameter int                   DSI_CHANNELS = elip_pkg::DSI_CHANNELS_DEF,
    parameter elip_pkg::elip_addr_t TDMA_BASE    = elip_pkg::TDMA_BASE_DEF,
    parameter elip_pkg::elip_addr_t TDMA_STRIDE  = elip_pkg::TDMA_STRIDE_DEF,
    parameter int                   REQ_CREDITS  = 4,
    parameter int                   RSP_CREDITS  = 2
) (
    input  logic                  elip,
    input  logic                  rst,
    input  elip_pkg::elip_req_t   req,
    input  logic                  req_valid,
    output logic                  req_credit,
    output elip_pkg::elip_rsp_t   rsp,
    output logic                  rsp_valid,
    input  logic                  rsp_credit,
    input  elip_pkg::tdma_load_t  load,
    input  logic                  load_valid
);

    logic [DSI_CHANNELS-1:0] tdma_rd;
    elip_pkg::tdma_idx_t     tdma_idx;     // shared by all tables.
    elip_pkg::data_ecc_t     tdma_data [DSI_CHANNELS];

    elip_demuxer #(
        .DSI_CHANNELS (DSI_CHANNELS),
        .TDMA_BASE    (TDMA_BASE),
        .TDMA_STRIDE  (TDMA_STRIDE),
        .REQ_CREDITS  (REQ_CREDITS),
        .RSP_CREDITS  (RSP_CREDITS)
    ) u_demuxer (
        .elip       (elip),
        .rst        (rst),
        .req        (req),
        .req_valid  (req_valid),
        .req_credit (req_credit),
        .tdma_rd    (tdma_rd),
        .tdma_idx   (tdma_idx),
        .tdma_data  (tdma_data),
        .rsp        (rsp),
        .rsp_valid  (rsp_valid),
        .rsp_credit (rsp_credit)
    );

    // ------------------------------
    // channel tables
    // ------------------------------
    for (genvar c = 0; c < DSI_CHANNELS; c++) begin : g_tbl
        logic load_en;

        // out of range channel numbers match no table.
        assign load_en = load_valid && (load.chan == elip_pkg::tdma_chan_t'(c));

        elip_tdma_table u_table (
            .elip      (elip),
            .rst       (rst),
            .load_data (load.data),
            .load_idx  (load.idx),
            .load_en   (load_en),
            .rd        (tdma_rd[c]),
            .rd_idx    (tdma_idx),
            .rd_data   (tdma_data[c])
        );
    end

endmodule

//--- rtl/elip_tdma_table.sv
// One channel's TDMA schedule table with ECC stored at load time and registered read.

module elip_tdma_table (
    input  logic                  elip,
    input  logic                  rst,
    input  elip_pkg::elip_data_t  load_data,
    input  elip_pkg::tdma_idx_t   load_idx,
    input  logic                  load_en,
    input  logic                  rd,
    input  elip_pkg::tdma_idx_t   rd_idx,
    output elip_pkg::data_ecc_t   rd_data
);

    elip_pkg::data_ecc_t mem [elip_pkg::TDMA_WORDS];
    elip_pkg::elip_ecc_t load_ecc;

    elip_ecc_enc u_ecc (
        .data (load_data),
        .ecc  (load_ecc)
    );

    // ------------------------------
    // storage
    // ------------------------------
    // the code is linear, so an all-zero word already carries valid check bits
    always_ff @(posedge elip) begin
        if (rst) begin
            for (int w = 0; w < elip_pkg::TDMA_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (load_en) begin
            mem[load_idx] <= '{data: load_data, ecc: load_ecc};
        end
    end

    // ------------------------------
    // read port
    // ------------------------------
    always_ff @(posedge elip) begin
        if (rd) begin
            rd_data <= mem[rd_idx];  // one cycle latency.
        end
    end

    // the demuxer must keep its read strobes quiet until reset is released
    a_no_rd_in_rst: assert property (@(posedge elip) rst |-> !rd)
        else $error("table read during reset");

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f sim.f --top-module elip_tb -o elip_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/elip_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1

//--- sim.f
rtl/elip_pkg.sv
rtl/elip_ecc_enc.sv
rtl/elip_tdma_table.sv
rtl/elip_demuxer.sv
rtl/elip_subsystem.sv
dv/elip_tb.sv
